// ==== design/ising_csr.sv ====
`default_nettype none

`include "ising_params.svh"

module ising_csr (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  ising_pkg::addr_t      addr,
    input  ising_pkg::data_t      wdata,
    input  logic                  busy,
    input  logic                  done,
    input  ising_pkg::count_t     phase,
    input  ising_pkg::spin_vec_t  spins,
    output ising_pkg::data_t      rdata,
    output logic                  rdata_valid,
    output logic                  start_pulse,
    output ising_pkg::count_t     counter_max,
    output ising_pkg::count_t     counter_cutoff,
    output ising_pkg::count_t     run_len,
    output ising_pkg::spin_vec_t  ext_spin,
    output ising_pkg::spin_idx_t  phase_sel
);

    ising_pkg::addr_t phase_offset;
    logic             phase_hit;
    logic             start_req;
    logic             done_flag;
    ising_pkg::data_t rdata_nxt;

    // the phase window decode picks the counter that the sampler returns through phase_sel
    assign phase_offset = addr - `ISING_PHASE_BASE;
    assign phase_sel    = ising_pkg::spin_idx_t'(phase_offset >> 2);
    assign phase_hit    = (addr >= `ISING_PHASE_BASE) &&
                          ((phase_offset >> 2) < `ISING_N_SPINS) &&
                          (addr[1:0] == 2'b00);

    // a write landing while the pulse is still out would slip in before busy rises
    assign start_req = wr_en && (addr == `ISING_ADDR_CTRL) && wdata[0] &&
                       !busy && !start_pulse;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= start_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            counter_max    <= '0;
            counter_cutoff <= '0;
            run_len        <= '0;
            ext_spin       <= '0;
        end else if (wr_en) begin
            case (addr)
                `ISING_ADDR_MAX:      counter_max    <= wdata;
                `ISING_ADDR_CUTOFF:   counter_cutoff <= wdata;
                `ISING_ADDR_RUN_LEN:  run_len        <= wdata;
                `ISING_ADDR_EXT_SPIN: ext_spin       <= wdata[`ISING_N_SPINS-1:0];
                default: ;
            endcase
        end
    end

    // sticky until the next run starts
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_flag <= 1'b0;
        end else if (done) begin
            done_flag <= 1'b1;
        end else if (start_pulse) begin
            done_flag <= 1'b0;
        end
    end

    always_comb begin
        rdata_nxt = '0;
        case (addr)
            `ISING_ADDR_CTRL:     rdata_nxt = ising_pkg::data_t'({done_flag, busy});
            `ISING_ADDR_MAX:      rdata_nxt = counter_max;
            `ISING_ADDR_CUTOFF:   rdata_nxt = counter_cutoff;
            `ISING_ADDR_RUN_LEN:  rdata_nxt = run_len;
            `ISING_ADDR_EXT_SPIN: rdata_nxt = ising_pkg::data_t'(ext_spin);
            `ISING_ADDR_SPINS:    rdata_nxt = ising_pkg::data_t'(spins);
            default: begin
                if (phase_hit) begin
                    rdata_nxt = phase;
                end
            end
        endcase
    end

    // read data appears one cycle after the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata       <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_en;
            if (rd_en) begin
                rdata <= rdata_nxt;
            end
        end
    end

    // the timer and sampler both count on a start only ever reaching an idle timer
    a_start_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        start_pulse |-> !busy
    );

endmodule

`default_nettype wire

// ==== design/ising_params.svh ====
`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

// number of coupled oscillators read out by the sampler
`define ISING_N_SPINS 8

// width of the phase counters and of every count setting
`define ISING_COUNT_W 32

// bus widths
`define ISING_ADDR_W 8
`define ISING_DATA_W 32

// wide enough to index every spin
`define ISING_SPIN_IDX_W 3

// register map, byte addresses on the 8-bit bus
`define ISING_ADDR_CTRL     8'h00
`define ISING_ADDR_MAX      8'h04
`define ISING_ADDR_CUTOFF   8'h08
`define ISING_ADDR_RUN_LEN  8'h0C
`define ISING_ADDR_EXT_SPIN 8'h10
`define ISING_ADDR_SPINS    8'h14

// phase counter of spin i sits at base + 4*i
`define ISING_PHASE_BASE    8'h40

`endif

// ==== design/ising_pkg.sv ====
`default_nettype none

`include "ising_params.svh"

package ising_pkg;

    // one bit per oscillator
    typedef logic [`ISING_N_SPINS-1:0] spin_vec_t;

    // phase counter value, also used for ceiling, cutoff and run length
    typedef logic [`ISING_COUNT_W-1:0] count_t;

    typedef logic [`ISING_ADDR_W-1:0] addr_t;

    typedef logic [`ISING_DATA_W-1:0] data_t;

    typedef logic [`ISING_SPIN_IDX_W-1:0] spin_idx_t;

    // run timer states
    typedef enum logic {
        RUN_IDLE,
        RUN_ACTIVE
    } run_state_t;

endpackage

`default_nettype wire

// ==== design/ising_sampler_top.sv ====
`default_nettype none

module ising_sampler_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  ising_pkg::addr_t      addr,
    input  ising_pkg::data_t      wdata,
    input  ising_pkg::spin_vec_t  osc_out,
    output ising_pkg::data_t      rdata,
    output logic                  rdata_valid,
    output logic                  run_busy,
    output logic                  run_done
);

    logic                 start_pulse;
    logic                 busy;
    logic                 done;
    ising_pkg::count_t    counter_max;
    ising_pkg::count_t    counter_cutoff;
    ising_pkg::count_t    run_len;
    ising_pkg::spin_vec_t ext_spin;
    ising_pkg::spin_idx_t phase_sel;
    ising_pkg::count_t    phase;
    ising_pkg::spin_vec_t ge_cutoff;
    ising_pkg::spin_vec_t spins;

    ising_csr csr0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .wr_en          (wr_en),
        .rd_en          (rd_en),
        .addr           (addr),
        .wdata          (wdata),
        .busy           (busy),
        .done           (done),
        .phase          (phase),
        .spins          (spins),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid),
        .start_pulse    (start_pulse),
        .counter_max    (counter_max),
        .counter_cutoff (counter_cutoff),
        .run_len        (run_len),
        .ext_spin       (ext_spin),
        .phase_sel      (phase_sel)
    );

    run_timer timer0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .start_pulse (start_pulse),
        .run_len     (run_len),
        .busy        (busy),
        .done        (done)
    );

    phase_sampler sampler0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .osc_out        (osc_out),
        .ext_spin       (ext_spin),
        .start_pulse    (start_pulse),
        .busy           (busy),
        .counter_max    (counter_max),
        .counter_cutoff (counter_cutoff),
        .phase_sel      (phase_sel),
        .phase          (phase),
        .ge_cutoff      (ge_cutoff)
    );

    spin_readout readout0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .done      (done),
        .ge_cutoff (ge_cutoff),
        .ext_spin  (ext_spin),
        .spins     (spins)
    );

    assign run_busy = busy;
    assign run_done = done;

endmodule

`default_nettype wire

// ==== design/phase_sampler.sv ====
`default_nettype none

`include "ising_params.svh"

module phase_sampler (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ising_pkg::spin_vec_t  osc_out,
    input  ising_pkg::spin_vec_t  ext_spin,
    input  logic                  start_pulse,
    input  logic                  busy,
    input  ising_pkg::count_t     counter_max,
    input  ising_pkg::count_t     counter_cutoff,
    input  ising_pkg::spin_idx_t  phase_sel,
    output ising_pkg::count_t     phase,
    output ising_pkg::spin_vec_t  ge_cutoff
);

    ising_pkg::spin_vec_t mismatch_raw;
    ising_pkg::spin_vec_t mismatch_q1;
    ising_pkg::spin_vec_t mismatch_q2;
    ising_pkg::spin_vec_t mismatch_q3;
    ising_pkg::count_t    phase_all [`ISING_N_SPINS];

    // sampling the xor tells us whether each oscillator is in phase with its reference
    assign mismatch_raw = osc_out ^ ext_spin;

    // osc_out comes straight off the analog array, so three flops before use
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mismatch_q1 <= '0;
            mismatch_q2 <= '0;
            mismatch_q3 <= '0;
        end else begin
            mismatch_q1 <= mismatch_raw;
            mismatch_q2 <= mismatch_q1;
            mismatch_q3 <= mismatch_q2;
        end
    end

    for (genvar i = 0; i < `ISING_N_SPINS; i++) begin : g_spin
        // up on agreement, down on disagreement, pinned at both ends
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                phase_all[i] <= '0;
            end else if (start_pulse) begin
                phase_all[i] <= counter_cutoff;
            end else if (busy) begin
                if (mismatch_q3[i]) begin
                    if (phase_all[i] != '0) begin
                        phase_all[i] <= phase_all[i] - 1'b1;
                    end
                end else if (phase_all[i] < counter_max) begin
                    phase_all[i] <= phase_all[i] + 1'b1;
                end
            end
        end

        assign ge_cutoff[i] = (phase_all[i] >= counter_cutoff);

        // only meaningful when the run started at or below the ceiling
        a_below_max : assert property (
            @(posedge clk) disable iff (!arst_n)
            (busy && (counter_cutoff <= counter_max)) |-> (phase_all[i] <= counter_max)
        );
    end

    assign phase = phase_all[phase_sel];

endmodule

`default_nettype wire

// ==== design/run_timer.sv ====
`default_nettype none

module run_timer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start_pulse,
    input  ising_pkg::count_t run_len,
    output logic              busy,
    output logic              done
);

    ising_pkg::run_state_t state;
    ising_pkg::run_state_t state_nxt;
    ising_pkg::count_t     remaining;
    ising_pkg::count_t     remaining_nxt;
    logic                  done_nxt;

    always_comb begin
        state_nxt     = state;
        remaining_nxt = remaining;
        done_nxt      = 1'b0;
        case (state)
            ising_pkg::RUN_IDLE: begin
                if (start_pulse) begin
                    if (run_len != '0) begin
                        state_nxt     = ising_pkg::RUN_ACTIVE;
                        remaining_nxt = run_len;
                    end else begin
                        // empty run finishes straight away
                        done_nxt = 1'b1;
                    end
                end
            end
            ising_pkg::RUN_ACTIVE: begin
                remaining_nxt = remaining - 1'b1;
                if (remaining == ising_pkg::count_t'(1)) begin
                    state_nxt = ising_pkg::RUN_IDLE;
                    done_nxt  = 1'b1;
                end
            end
            default: state_nxt = ising_pkg::RUN_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ising_pkg::RUN_IDLE;
            remaining <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= state_nxt;
            remaining <= remaining_nxt;
            busy      <= (state_nxt == ising_pkg::RUN_ACTIVE);
            done      <= done_nxt;
        end
    end

    a_done_not_busy : assert property (
        @(posedge clk) disable iff (!arst_n) done |-> !busy
    );

    // the countdown stays above zero for as long as the run is active
    a_busy_remaining : assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> (remaining != '0)
    );

endmodule

`default_nettype wire

// ==== design/spin_readout.sv ====
`default_nettype none

module spin_readout (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  done,
    input  ising_pkg::spin_vec_t  ge_cutoff,
    input  ising_pkg::spin_vec_t  ext_spin,
    output ising_pkg::spin_vec_t  spins
);

    ising_pkg::spin_vec_t spin_abs;

    // a set decision means the oscillator tracked its reference bit,
    // so the absolute phase is the reference where set and its inverse where clear
    assign spin_abs = ge_cutoff ^ ~ext_spin;

    // counters are frozen once busy drops, so the done cycle sees final values
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spins <= '0;
        end else if (done) begin
            spins <= spin_abs;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset spans the first five rising edges and lets go on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/tb_ising_sampler.sv ====
`default_nettype none

`include "ising_params.svh"

module tb_ising_sampler;

    // nine runs of at most 150 busy cycles plus a few hundred bus cycles, with wide margin
    localparam int MAX_CYCLES = 20000;

    logic                 clk;
    logic                 arst_n;
    logic                 wr_en;
    logic                 rd_en;
    ising_pkg::addr_t     addr;
    ising_pkg::data_t     wdata;
    ising_pkg::spin_vec_t osc_out;
    ising_pkg::data_t     rdata;
    logic                 rdata_valid;
    logic                 run_busy;
    logic                 run_done;
    int                   cycle_count = 0;

    tb_clk_gen clk_gen0 (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ising_sampler_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wdata       (wdata),
        .osc_out     (osc_out),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .run_busy    (run_busy),
        .run_done    (run_done)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Checks failed");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic check_data(input string name, input ising_pkg::data_t got,
                              input ising_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_count(input string name, input ising_pkg::count_t got,
                               input ising_pkg::count_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_spins(input string name, input ising_pkg::spin_vec_t got,
                               input ising_pkg::spin_vec_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // every bus task starts and ends just after a falling edge
    task automatic bus_write(input ising_pkg::addr_t a, input ising_pkg::data_t d);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic bus_read(input ising_pkg::addr_t a, output ising_pkg::data_t d);
        @(negedge clk);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        while (!rdata_valid) begin
            @(negedge clk);
        end
        d = rdata;
    endtask

    // a steady run climbs to the ceiling on agreement and falls to zero otherwise
    function automatic ising_pkg::count_t expected_phase(input bit agree,
                                                         input ising_pkg::count_t cutoff,
                                                         input ising_pkg::count_t len,
                                                         input ising_pkg::count_t ceiling);
        longint sum;
        sum = longint'(cutoff) + longint'(len);
        if (agree) begin
            return (sum > longint'(ceiling)) ? ceiling : ising_pkg::count_t'(sum);
        end
        return (len >= cutoff) ? '0 : cutoff - len;
    endfunction

    task automatic check_all_phases(input ising_pkg::spin_vec_t ext,
                                    input ising_pkg::spin_vec_t osc,
                                    input ising_pkg::count_t ceiling,
                                    input ising_pkg::count_t cutoff,
                                    input ising_pkg::count_t len);
        ising_pkg::data_t val;
        for (int i = 0; i < `ISING_N_SPINS; i++) begin
            bus_read(ising_pkg::addr_t'(`ISING_PHASE_BASE + 4 * i), val);
            check_count($sformatf("phase[%0d]", i), val,
                        expected_phase(osc[i] == ext[i], cutoff, len, ceiling));
        end
    endtask

    task automatic run_and_check(input ising_pkg::spin_vec_t ext,
                                 input ising_pkg::spin_vec_t osc,
                                 input ising_pkg::count_t ceiling,
                                 input ising_pkg::count_t cutoff,
                                 input ising_pkg::count_t len);
        ising_pkg::data_t val;
        osc_out = osc;
        bus_write(`ISING_ADDR_EXT_SPIN, ising_pkg::data_t'(ext));
        bus_write(`ISING_ADDR_MAX, ceiling);
        bus_write(`ISING_ADDR_CUTOFF, cutoff);
        bus_write(`ISING_ADDR_RUN_LEN, len);
        bus_write(`ISING_ADDR_CTRL, 32'h1);
        // the start clears the complete flag of the previous run
        bus_read(`ISING_ADDR_CTRL, val);
        check_data("status while running", val, 32'h1);
        while (!run_done) begin
            @(negedge clk);
        end
        check_all_phases(ext, osc, ceiling, cutoff, len);
        bus_read(`ISING_ADDR_SPINS, val);
        check_spins("spins", ising_pkg::spin_vec_t'(val), osc);
        bus_read(`ISING_ADDR_CTRL, val);
        check_data("status", val, 32'h2);
    endtask

    task automatic test_reset_regs();
        ising_pkg::data_t val;
        ising_pkg::addr_t regs [6] = '{`ISING_ADDR_CTRL, `ISING_ADDR_MAX,
            `ISING_ADDR_CUTOFF, `ISING_ADDR_RUN_LEN, `ISING_ADDR_EXT_SPIN, `ISING_ADDR_SPINS};
        ising_pkg::data_t vals [4] = '{32'hDEADBEEF, 32'h12345678, 32'h0000ABCD, 32'h000000A5};
        for (int i = 0; i < 6; i++) begin
            bus_read(regs[i], val);
            check_data($sformatf("reg 0x%h after reset", regs[i]), val, '0);
        end
        check_all_phases('0, '0, '0, '0, '0);
        for (int i = 0; i < 4; i++) begin
            bus_write(regs[i + 1], vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(regs[i + 1], val);
            check_data($sformatf("reg 0x%h", regs[i + 1]), val, vals[i]);
        end
    endtask

    task automatic test_random_mix();
        ising_pkg::spin_vec_t ext;
        ising_pkg::spin_vec_t osc;
        ising_pkg::count_t    cutoff;
        for (int round = 0; round < 4; round++) begin
            ext    = ising_pkg::spin_vec_t'($urandom);
            osc    = ising_pkg::spin_vec_t'($urandom);
            cutoff = ising_pkg::count_t'(1 + ($urandom % 200));
            run_and_check(ext, osc, cutoff + ising_pkg::count_t'($urandom % 200), cutoff,
                          ising_pkg::count_t'(1 + ($urandom % 150)));
        end
    endtask

    // a start taken late in the run would reload the counters and leave them short
    task automatic test_run_timing();
        ising_pkg::data_t val;
        ising_pkg::addr_t empty [4] = '{8'h60, 8'h7C, 8'hFC, 8'h18};
        int busy_cycles;
        int done_pulses;
        int cyc;
        int settle;
        busy_cycles = 0;
        done_pulses = 0;
        cyc         = 0;
        settle      = 0;
        run_and_check(8'h0F, 8'h0F, 32'd1000, 32'd50, 32'd40);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = `ISING_ADDR_CTRL;
        wdata = 32'h1;
        while (settle < 5) begin
            @(negedge clk);
            wr_en = (cyc == 30);
            if (run_busy) begin
                busy_cycles++;
            end
            if (run_done) begin
                done_pulses++;
            end
            if (done_pulses != 0) begin
                settle++;
            end
            cyc++;
        end
        check_count("run_busy cycles", ising_pkg::count_t'(busy_cycles), 32'd40);
        check_count("run_done pulses", ising_pkg::count_t'(done_pulses), 32'd1);
        check_all_phases(8'h0F, 8'h0F, 32'd1000, 32'd50, 32'd40);
        for (int i = 0; i < 4; i++) begin
            bus_read(empty[i], val);
            check_data($sformatf("unmapped 0x%h", empty[i]), val, '0);
        end
    endtask

    initial begin
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        addr    = '0;
        wdata   = '0;
        osc_out = '0;
        void'($urandom(32'h5179));
        wait (arst_n === 1'b1);
        @(negedge clk);
        test_reset_regs();
        run_and_check(8'h3C, 8'h3C, 32'd1000, 32'd100, 32'd50);
        run_and_check(8'hF0, 8'hF0, 32'd120, 32'd100, 32'd50);
        run_and_check(8'hF0, 8'h0F, 32'd120, 32'd20, 32'd50);
        test_random_mix();
        test_run_timing();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ising_sampler.f ====
+incdir+design
design/ising_pkg.sv
design/ising_csr.sv
design/run_timer.sv
design/phase_sampler.sv
design/spin_readout.sv
design/ising_sampler_top.sv
dv/tb_clk_gen.sv
dv/tb_ising_sampler.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ising_sampler -f ising_sampler.f -o sim_ising_sampler

sim_out="$(./obj_dir/sim_ising_sampler 2>&1)" || true
echo "$sim_out"

if grep -q "All checks passed" <<< "$sim_out"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
